// ==== common/id_settings.svh ====
// ----------------------------------------------------------
// decode stage width settings
// ----------------------------------------------------------
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// data and pc width
`define ID_XLEN   64
`define ID_INST_W 32
`define ID_REG_AW 5
`define ID_OP_W   8

`endif

// ==== common/rv_isa_pkg.sv ====
// ----------------------------------------------------------
// rv64i instruction encoding
// major opcodes and the field layouts of one instruction word
// ----------------------------------------------------------
`default_nettype none
`include "id_settings.svh"

package rv_isa_pkg;

  // opcode bits 6:2
  typedef enum logic [4:0] {
    LOAD      = 5'b00000,
    OP_IMM    = 5'b00100,
    AUIPC     = 5'b00101,
    OP_IMM_32 = 5'b00110,
    STORE     = 5'b01000,
    OP        = 5'b01100,
    LUI       = 5'b01101,
    OP_32     = 5'b01110,
    BRANCH    = 5'b11000,
    JALR      = 5'b11001,
    JAL       = 5'b11011
  } major_op_e;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [`ID_REG_AW-1:0] rs2;
    logic [`ID_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`ID_REG_AW-1:0] rd;
    major_op_e             opc;
    logic [1:0]            quad;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]           imm;
    logic [`ID_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`ID_REG_AW-1:0] rd;
    major_op_e             opc;
    logic [1:0]            quad;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]            imm_hi;
    logic [`ID_REG_AW-1:0] rs2;
    logic [`ID_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_lo;
    major_op_e             opc;
    logic [1:0]            quad;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0]           imm;
    logic [`ID_REG_AW-1:0] rd;
    major_op_e             opc;
    logic [1:0]            quad;
  } u_fmt_t;

  // same word seen through each format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    u_fmt_t u;
  } inst_word_u;

endpackage

`default_nettype wire

// ==== common/id_pipe_pkg.sv ====
// ----------------------------------------------------------
// decode stage pipeline bundles
// fetch input, forwarding tags, decoder result, stage output
// ----------------------------------------------------------
`default_nettype none
`include "id_settings.svh"

package id_pipe_pkg;

  typedef enum logic [2:0] {
    NONE, REGREG, REGREGW, REGIMM, REGIMMW, BRANCH, LOAD, STORE
  } inst_class_e;

  // loads and stores carry no code, funct3 gives the access
  typedef enum logic [`ID_OP_W-1:0] {
    ILLEGAL = '0,
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
    OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
    OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
    OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU
  } id_op_e;

  typedef struct packed {
    rv_isa_pkg::inst_word_u inst;
    logic [`ID_XLEN-1:0]    pc;
  } fetch_t;

  typedef struct packed {
    logic                  wen;
    logic [`ID_REG_AW-1:0] addr;
    logic [`ID_XLEN-1:0]   data;
  } fwd_t;

  typedef struct packed {
    fwd_t fwd;
    logic is_load;
  } ex_fwd_t;

  typedef struct packed {
    logic                  wen;
    logic [`ID_REG_AW-1:0] addr;
  } wb_tag_t;

  typedef struct packed {
    inst_class_e           cls;
    id_op_e                op;
    logic                  rs1_ren;
    logic                  rs2_ren;
    logic [`ID_REG_AW-1:0] rs1;
    logic [`ID_REG_AW-1:0] rs2;
    logic                  rd_wen;
    logic [`ID_REG_AW-1:0] rd;
    logic [2:0]            funct3;
    // I immediate, or S immediate for stores
    logic [`ID_XLEN-1:0]   imm;
    logic [`ID_XLEN-1:0]   u_imm;
    logic                  op1_pc;
    logic                  op2_pc;
  } dec_t;

  typedef struct packed {
    inst_class_e            cls;
    id_op_e                 op;
    logic                   rd_wen;
    logic [`ID_REG_AW-1:0]  rd_addr;
    logic [`ID_XLEN-1:0]    op1;
    logic [`ID_XLEN-1:0]    op2;
    logic [2:0]             mem_op;
    logic [11:0]            mem_offset;
    logic [`ID_XLEN-1:0]    pc;
    rv_isa_pkg::inst_word_u inst;
  } id_out_t;

  typedef struct packed {
    logic                en;
    logic [`ID_XLEN-1:0] target;
  } redirect_t;

endpackage

`default_nettype wire

// ==== decode/inst_decoder.sv ====
// ----------------------------------------------------------
// rv64i instruction decoder
// class, operation, register use and immediates of one word
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "id_settings.svh"

module inst_decoder (
  input  rv_isa_pkg::inst_word_u inst_i,
  output id_pipe_pkg::dec_t      dec_o
);

  logic [2:0]               f3;
  logic                     alt;
  logic                     legal;
  id_pipe_pkg::inst_class_e cls;
  id_pipe_pkg::id_op_e      op;
  logic                     rs1_ren;
  logic                     rs2_ren;
  logic                     rd_wen;
  logic [11:0]              imm12;

  assign f3 = inst_i.r.funct3;
  // selects sub and the arithmetic shifts
  assign alt = inst_i.r.funct7[5];

  always_comb begin
    legal = 1'b1;
    cls   = id_pipe_pkg::NONE;
    op    = id_pipe_pkg::ILLEGAL;
    case (inst_i.r.opc)
      rv_isa_pkg::OP: begin
        cls = id_pipe_pkg::REGREG;
        case (f3)
          3'b000: op = alt ? id_pipe_pkg::OP_SUB : id_pipe_pkg::OP_ADD;
          3'b001: op = id_pipe_pkg::OP_SLL;
          3'b010: op = id_pipe_pkg::OP_SLT;
          3'b011: op = id_pipe_pkg::OP_SLTU;
          3'b100: op = id_pipe_pkg::OP_XOR;
          3'b101: op = alt ? id_pipe_pkg::OP_SRA : id_pipe_pkg::OP_SRL;
          3'b110: op = id_pipe_pkg::OP_OR;
          default: op = id_pipe_pkg::OP_AND;
        endcase
      end
      rv_isa_pkg::OP_IMM: begin
        cls = id_pipe_pkg::REGIMM;
        case (f3)
          3'b000: op = id_pipe_pkg::OP_ADDI;
          3'b001: op = id_pipe_pkg::OP_SLLI;
          3'b010: op = id_pipe_pkg::OP_SLTI;
          3'b011: op = id_pipe_pkg::OP_SLTIU;
          3'b100: op = id_pipe_pkg::OP_XORI;
          3'b101: op = alt ? id_pipe_pkg::OP_SRAI : id_pipe_pkg::OP_SRLI;
          3'b110: op = id_pipe_pkg::OP_ORI;
          default: op = id_pipe_pkg::OP_ANDI;
        endcase
      end
      rv_isa_pkg::OP_32: begin
        cls = id_pipe_pkg::REGREGW;
        case (f3)
          3'b000: op = alt ? id_pipe_pkg::OP_SUBW : id_pipe_pkg::OP_ADDW;
          3'b001: op = id_pipe_pkg::OP_SLLW;
          3'b101: op = alt ? id_pipe_pkg::OP_SRAW : id_pipe_pkg::OP_SRLW;
          default: legal = 1'b0;
        endcase
      end
      rv_isa_pkg::OP_IMM_32: begin
        cls = id_pipe_pkg::REGIMMW;
        case (f3)
          3'b000: op = id_pipe_pkg::OP_ADDIW;
          3'b001: op = id_pipe_pkg::OP_SLLIW;
          3'b101: op = alt ? id_pipe_pkg::OP_SRAIW : id_pipe_pkg::OP_SRLIW;
          default: legal = 1'b0;
        endcase
      end
      rv_isa_pkg::BRANCH: begin
        cls = id_pipe_pkg::BRANCH;
        case (f3)
          3'b000: op = id_pipe_pkg::OP_BEQ;
          3'b001: op = id_pipe_pkg::OP_BNE;
          3'b100: op = id_pipe_pkg::OP_BLT;
          3'b101: op = id_pipe_pkg::OP_BGE;
          3'b110: op = id_pipe_pkg::OP_BLTU;
          3'b111: op = id_pipe_pkg::OP_BGEU;
          default: legal = 1'b0;
        endcase
      end
      rv_isa_pkg::LOAD: begin
        cls   = id_pipe_pkg::LOAD;
        legal = (f3 != 3'b111);
      end
      rv_isa_pkg::STORE: begin
        cls   = id_pipe_pkg::STORE;
        legal = ~f3[2];
      end
      rv_isa_pkg::LUI: op = id_pipe_pkg::OP_LUI;
      rv_isa_pkg::AUIPC: op = id_pipe_pkg::OP_AUIPC;
      rv_isa_pkg::JAL: op = id_pipe_pkg::OP_JAL;
      rv_isa_pkg::JALR: begin
        op    = id_pipe_pkg::OP_JALR;
        legal = (f3 == 3'b000);
      end
      default: legal = 1'b0;
    endcase
    // funct7 bit 0 marks the M extension, not supported here
    if (inst_i.r.opc inside {rv_isa_pkg::OP, rv_isa_pkg::OP_32} && inst_i.r.funct7[0])
      legal = 1'b0;
    if (inst_i.r.quad != 2'b11)
      legal = 1'b0;
    if (!legal) begin
      cls = id_pipe_pkg::NONE;
      op  = id_pipe_pkg::ILLEGAL;
    end
  end

  // every class but NONE reads rs1
  assign rs1_ren = (cls != id_pipe_pkg::NONE) || (op == id_pipe_pkg::OP_JALR);
  assign rs2_ren = cls inside {id_pipe_pkg::REGREG, id_pipe_pkg::REGREGW,
                               id_pipe_pkg::BRANCH, id_pipe_pkg::STORE};
  assign rd_wen  = (inst_i.r.rd != '0) &&
                   ((cls inside {id_pipe_pkg::REGREG, id_pipe_pkg::REGREGW,
                                 id_pipe_pkg::REGIMM, id_pipe_pkg::REGIMMW,
                                 id_pipe_pkg::LOAD}) ||
                    (op inside {id_pipe_pkg::OP_LUI, id_pipe_pkg::OP_AUIPC,
                                id_pipe_pkg::OP_JAL, id_pipe_pkg::OP_JALR}));

  assign imm12 = (cls == id_pipe_pkg::STORE) ? {inst_i.s.imm_hi, inst_i.s.imm_lo} :
                                               inst_i.i.imm;

  always_comb begin
    dec_o.cls     = cls;
    dec_o.op      = op;
    dec_o.rs1_ren = rs1_ren;
    dec_o.rs2_ren = rs2_ren;
    dec_o.rs1     = rs1_ren ? inst_i.r.rs1 : '0;
    dec_o.rs2     = rs2_ren ? inst_i.r.rs2 : '0;
    dec_o.rd_wen  = rd_wen;
    dec_o.rd      = rd_wen ? inst_i.r.rd : '0;
    dec_o.funct3  = f3;
    dec_o.imm     = {{(`ID_XLEN-12){imm12[11]}}, imm12};
    // upper immediate is a signed 32-bit value on rv64
    dec_o.u_imm   = {{(`ID_XLEN-`ID_INST_W){inst_i.u.imm[19]}}, inst_i.u.imm, 12'b0};
    dec_o.op1_pc  = op inside {id_pipe_pkg::OP_AUIPC, id_pipe_pkg::OP_JAL};
    dec_o.op2_pc  = op inside {id_pipe_pkg::OP_JAL, id_pipe_pkg::OP_JALR};
  end

endmodule

`default_nettype wire

// ==== source/operand_bypass.sv ====
// ----------------------------------------------------------
// operand forwarding and load-use detection
// builds op1 and op2 from execute, memory or the register file
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "id_settings.svh"

module operand_bypass (
  input  id_pipe_pkg::dec_t    dec_i,
  input  logic [`ID_XLEN-1:0]  pc_i,
  input  logic [`ID_XLEN-1:0]  rs1_data_i,
  input  logic [`ID_XLEN-1:0]  rs2_data_i,
  input  id_pipe_pkg::ex_fwd_t ex_fwd_i,
  input  id_pipe_pkg::fwd_t    mem_fwd_i,
  output logic [`ID_XLEN-1:0]  op1_o,
  output logic [`ID_XLEN-1:0]  op2_o,
  output logic                 rs1_ex_hit_o,
  output logic                 rs1_mem_hit_o,
  output logic                 stall_o
);

  logic rs2_ex_hit;
  logic rs2_mem_hit;
  logic imm_class;
  logic u_type;

  function automatic logic hit(id_pipe_pkg::fwd_t f, logic ren,
                               logic [`ID_REG_AW-1:0] addr);
    return ren && f.wen && (f.addr == addr);
  endfunction

  // execute is newest, then memory, then the register file
  function automatic logic [`ID_XLEN-1:0] pick(logic ex_hit, logic mem_hit,
                                               logic [`ID_XLEN-1:0] rf_data);
    if (ex_hit)
      return ex_fwd_i.fwd.data;
    if (mem_hit)
      return mem_fwd_i.data;
    return rf_data;
  endfunction

  assign rs1_ex_hit_o  = hit(ex_fwd_i.fwd, dec_i.rs1_ren, dec_i.rs1);
  assign rs1_mem_hit_o = hit(mem_fwd_i, dec_i.rs1_ren, dec_i.rs1);
  assign rs2_ex_hit    = hit(ex_fwd_i.fwd, dec_i.rs2_ren, dec_i.rs2);
  assign rs2_mem_hit   = hit(mem_fwd_i, dec_i.rs2_ren, dec_i.rs2);

  // load data only exists after memory
  assign stall_o = ex_fwd_i.is_load && (rs1_ex_hit_o || rs2_ex_hit);

  assign imm_class = dec_i.cls inside {id_pipe_pkg::REGIMM, id_pipe_pkg::REGIMMW};
  assign u_type    = dec_i.op inside {id_pipe_pkg::OP_LUI, id_pipe_pkg::OP_AUIPC};

  always_comb begin
    if (dec_i.rs1_ren)
      op1_o = pick(rs1_ex_hit_o, rs1_mem_hit_o, rs1_data_i);
    else if (dec_i.op1_pc)
      op1_o = pc_i;
    else
      op1_o = '0;
  end

  always_comb begin
    if (dec_i.rs2_ren)
      op2_o = pick(rs2_ex_hit, rs2_mem_hit, rs2_data_i);
    else if (imm_class)
      op2_o = dec_i.imm;
    else if (u_type)
      op2_o = dec_i.u_imm;
    else if (dec_i.op2_pc)
      op2_o = pc_i;
    else
      op2_o = '0;
  end

endmodule

`default_nettype wire

// ==== source/jalr_redirect.sv ====
// ----------------------------------------------------------
// jalr redirect
// target of a jalr whose base register is still in flight
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "id_settings.svh"

module jalr_redirect (
  input  id_pipe_pkg::dec_t      dec_i,
  input  logic [`ID_XLEN-1:0]    op1_i,
  input  logic                   rs1_ex_hit_i,
  input  logic                   rs1_mem_hit_i,
  input  id_pipe_pkg::wb_tag_t   wb_i,
  output id_pipe_pkg::redirect_t redirect_o
);

  logic                rs1_wb_hit;
  logic [`ID_XLEN-1:0] sum;

  assign rs1_wb_hit = dec_i.rs1_ren && wb_i.wen && (wb_i.addr == dec_i.rs1);
  assign sum        = op1_i + dec_i.imm;

  // fetch guessed with a stale base
  always_comb begin
    redirect_o.en     = (dec_i.op == id_pipe_pkg::OP_JALR) &&
                        (rs1_ex_hit_i || rs1_mem_hit_i || rs1_wb_hit);
    redirect_o.target = redirect_o.en ? {sum[`ID_XLEN-1:1], 1'b0} : '0;
  end

endmodule

`default_nettype wire

// ==== source/id_handshake_reg.sv ====
// ----------------------------------------------------------
// decode stage output register
// four-phase req/ack on the fetch side, holds the result
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module id_handshake_reg (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   req_i,
  input  logic                   stall_i,
  input  id_pipe_pkg::id_out_t   next_i,
  input  id_pipe_pkg::redirect_t redirect_i,
  output logic                   ack_o,
  output id_pipe_pkg::id_out_t   id_out_o,
  output id_pipe_pkg::redirect_t redirect_o
);

  logic accept;

  // new request, previous exchange closed, no load-use hazard
  assign accept = req_i && !ack_o && !stall_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_o <= 1'b0;
    end else if (accept) begin
      ack_o <= 1'b1;
    end else if (!req_i) begin
      ack_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      id_out_o.rd_wen <= 1'b0;
      id_out_o.op     <= id_pipe_pkg::ILLEGAL;
      redirect_o.en   <= 1'b0;
    end else if (accept) begin
      id_out_o   <= next_i;
      redirect_o <= redirect_i;
    end
  end

endmodule

`default_nettype wire

// ==== source/id_stage_top.sv ====
// ----------------------------------------------------------
// instruction decode stage
// decoder, operand bypass, jalr redirect and output register
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "id_settings.svh"

module id_stage_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   req_i,
  input  id_pipe_pkg::fetch_t    fetch_i,
  input  logic [`ID_XLEN-1:0]    rs1_data_i,
  input  logic [`ID_XLEN-1:0]    rs2_data_i,
  input  id_pipe_pkg::ex_fwd_t   ex_fwd_i,
  input  id_pipe_pkg::fwd_t      mem_fwd_i,
  input  id_pipe_pkg::wb_tag_t   wb_i,
  output logic                   ack_o,
  output logic [`ID_REG_AW-1:0]  rs1_addr_o,
  output logic [`ID_REG_AW-1:0]  rs2_addr_o,
  output logic                   stall_o,
  output id_pipe_pkg::id_out_t   id_out_o,
  output id_pipe_pkg::redirect_t redirect_o
);

  id_pipe_pkg::dec_t      dec;
  logic [`ID_XLEN-1:0]    op1;
  logic [`ID_XLEN-1:0]    op2;
  logic                   rs1_ex_hit;
  logic                   rs1_mem_hit;
  id_pipe_pkg::id_out_t   id_next;
  id_pipe_pkg::redirect_t redirect;

  inst_decoder u_dec (
    .inst_i (fetch_i.inst),
    .dec_o  (dec)
  );

  operand_bypass u_bypass (
    .dec_i         (dec),
    .pc_i          (fetch_i.pc),
    .rs1_data_i    (rs1_data_i),
    .rs2_data_i    (rs2_data_i),
    .ex_fwd_i      (ex_fwd_i),
    .mem_fwd_i     (mem_fwd_i),
    .op1_o         (op1),
    .op2_o         (op2),
    .rs1_ex_hit_o  (rs1_ex_hit),
    .rs1_mem_hit_o (rs1_mem_hit),
    .stall_o       (stall_o)
  );

  jalr_redirect u_jalr (
    .dec_i         (dec),
    .op1_i         (op1),
    .rs1_ex_hit_i  (rs1_ex_hit),
    .rs1_mem_hit_i (rs1_mem_hit),
    .wb_i          (wb_i),
    .redirect_o    (redirect)
  );

  // register file read ports
  assign rs1_addr_o = dec.rs1;
  assign rs2_addr_o = dec.rs2;

  always_comb begin
    id_next.cls        = dec.cls;
    id_next.op         = dec.op;
    id_next.rd_wen     = dec.rd_wen;
    id_next.rd_addr    = dec.rd;
    id_next.op1        = op1;
    id_next.op2        = op2;
    id_next.mem_op     = dec.funct3;
    // decoder already picked I or S layout
    id_next.mem_offset = (dec.cls inside {id_pipe_pkg::LOAD, id_pipe_pkg::STORE}) ?
                         dec.imm[11:0] : '0;
    id_next.pc         = fetch_i.pc;
    id_next.inst       = fetch_i.inst;
  end

  id_handshake_reg u_hs (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_i      (req_i),
    .stall_i    (stall_o),
    .next_i     (id_next),
    .redirect_i (redirect),
    .ack_o      (ack_o),
    .id_out_o   (id_out_o),
    .redirect_o (redirect_o)
  );

endmodule

`default_nettype wire

// ==== dv/id_stage_chk.sv ====
// ----------------------------------------------------------
// decode stage handshake checks
// bound into the stage top level
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module id_stage_chk (
  input logic clk_i,
  input logic rst_i,
  input logic req_i,
  input logic stall_i,
  input logic ack_i
);

  int fail_count = 0;

  // acceptance edge saw the request
  ack_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(ack_i) |-> $past(req_i))
    else begin
      $error("ack rose without a request");
      fail_count++;
    end

  ack_not_stalled: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(ack_i) |-> !$past(stall_i))
    else begin
      $error("ack rose during a load-use stall");
      fail_count++;
    end

  ack_low_after_reset: assert property (@(posedge clk_i)
    $fell(rst_i) |-> !ack_i)
    else begin
      $error("ack high right after reset");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== dv/id_stage_tb.sv ====
// ----------------------------------------------------------
// decode stage testbench
// runs the case file through four-phase exchanges
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "id_settings.svh"

module id_stage_tb;

  localparam int CLK_HALF = 20;
  localparam int WAIT_MAX = 10;

  logic                   clk;
  logic                   rst;
  logic                   req;
  id_pipe_pkg::fetch_t    fetch;
  logic [`ID_XLEN-1:0]    rs1_data;
  logic [`ID_XLEN-1:0]    rs2_data;
  id_pipe_pkg::ex_fwd_t   ex_fwd;
  id_pipe_pkg::fwd_t      mem_fwd;
  id_pipe_pkg::wb_tag_t   wb;
  logic                   ack;
  logic [`ID_REG_AW-1:0]  rs1_addr;
  logic [`ID_REG_AW-1:0]  rs2_addr;
  logic                   stall;
  id_pipe_pkg::id_out_t   id_out;
  id_pipe_pkg::redirect_t redirect;

  logic [`ID_XLEN-1:0] rf [32];
  string               lines[$];
  int                  n_cases;
  int                  n_tests;
  int                  n_fail;
  int                  errors;
  bit                  cases_loaded;

  id_stage_top UUT (
    .clk_i      (clk),
    .rst_i      (rst),
    .req_i      (req),
    .fetch_i    (fetch),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .ex_fwd_i   (ex_fwd),
    .mem_fwd_i  (mem_fwd),
    .wb_i       (wb),
    .ack_o      (ack),
    .rs1_addr_o (rs1_addr),
    .rs2_addr_o (rs2_addr),
    .stall_o    (stall),
    .id_out_o   (id_out),
    .redirect_o (redirect)
  );

  bind id_stage_top id_stage_chk u_chk (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .req_i   (req_i),
    .stall_i (stall_o),
    .ack_i   (ack_o)
  );

  // register file model, same-cycle read
  assign rs1_data = rf[rs1_addr];
  assign rs2_data = rf[rs2_addr];

  always #CLK_HALF clk = ~clk;

  task automatic check_class(string name, id_pipe_pkg::inst_class_e exp,
                             id_pipe_pkg::inst_class_e act);
    if (act !== exp) begin
      $display("FAILED %s class: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_op(string name, id_pipe_pkg::id_op_e exp, id_pipe_pkg::id_op_e act);
    if (act !== exp) begin
      $display("FAILED %s op: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_word(string name, string field, logic [`ID_XLEN-1:0] exp,
                            logic [`ID_XLEN-1:0] act);
    if (act !== exp) begin
      $display("FAILED %s %s: expected %h, actual %h", name, field, exp, act);
      errors++;
    end
  endtask

  task automatic check_redirect(string name, id_pipe_pkg::redirect_t exp,
                                id_pipe_pkg::redirect_t act);
    if (act !== exp) begin
      $display("FAILED %s redirect: expected %b/%h, actual %b/%h", name,
               exp.en, exp.target, act.en, act.target);
      errors++;
    end
  endtask

  // operand value for a source keyword of the case file
  function automatic logic [`ID_XLEN-1:0] source_value(string src, logic [4:0] rs,
      logic [31:0] inst, logic [`ID_XLEN-1:0] pc, logic [`ID_XLEN-1:0] ex_data,
      logic [`ID_XLEN-1:0] mem_data);
    logic [6:0] opc;
    opc = inst[6:0];
    if (src == "REG")
      return rf[rs];
    if (src == "EX")
      return ex_data;
    if (src == "MEM")
      return mem_data;
    if (src == "PC")
      return pc;
    if (src == "IMM") begin
      // lui and auipc take the upper immediate
      if (opc == 7'h37 || opc == 7'h17)
        return {{(`ID_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
      return {{(`ID_XLEN-12){inst[31]}}, inst[31:20]};
    end
    return '0;
  endfunction

  // read port address, zero for an operand that is not read
  function automatic logic [4:0] read_addr(string src, logic [4:0] field);
    if (src == "REG" || src == "EX" || src == "MEM")
      return field;
    return '0;
  endfunction

  task automatic run_case(string line);
    string                  name;
    string                  src1;
    string                  src2;
    logic [31:0]            inst;
    logic [`ID_XLEN-1:0]    pc;
    logic [`ID_XLEN-1:0]    ex_data;
    logic [`ID_XLEN-1:0]    mem_data;
    logic [`ID_XLEN-1:0]    op1_exp;
    logic [`ID_XLEN-1:0]    op2_exp;
    logic [`ID_XLEN-1:0]    sum;
    logic [11:0]            mem_off;
    int                     ex_wen, ex_addr, ex_load, mem_wen, mem_addr, wb_wen, wb_addr;
    int                     cls, op, rd_wen, rd_addr, redir, n, waited;
    id_pipe_pkg::redirect_t redir_exp;

    errors = 0;
    n_tests++;
    n = $sscanf(line, "%s %h %h %d %d %h %d %d %d %h %d %d %d %d %d %d %s %s %h %d",
                name, inst, pc, ex_wen, ex_addr, ex_data, ex_load, mem_wen, mem_addr,
                mem_data, wb_wen, wb_addr, cls, op, rd_wen, rd_addr, src1, src2,
                mem_off, redir);
    if (n != 20) begin
      $display("case line has %0d fields instead of 20: %s", n, line);
      n_fail++;
      return;
    end

    @(posedge clk);
    #2;
    fetch.inst          = inst;
    fetch.pc            = pc;
    ex_fwd.fwd.wen      = ex_wen[0];
    ex_fwd.fwd.addr     = ex_addr[4:0];
    ex_fwd.fwd.data     = ex_data;
    ex_fwd.is_load      = ex_load[0];
    mem_fwd.wen         = mem_wen[0];
    mem_fwd.addr        = mem_addr[4:0];
    mem_fwd.data        = mem_data;
    wb.wen              = wb_wen[0];
    wb.addr             = wb_addr[4:0];
    req                 = 1'b1;

    // load in execute: hold off, then retire the load
    if (ex_load != 0) begin
      @(negedge clk);
      if (stall !== 1'b1) begin
        $display("%s: stall was not raised for a load-use hazard", name);
        errors++;
      end
      repeat (3) begin
        @(negedge clk);
        if (ack !== 1'b0) begin
          $display("%s: ack rose while the stage was stalled", name);
          errors++;
        end
      end
      @(posedge clk);
      #2;
      ex_fwd = '0;
    end

    waited = 0;
    while (ack !== 1'b1 && waited < WAIT_MAX) begin
      @(negedge clk);
      waited++;
    end
    if (ack !== 1'b1) begin
      $display("%s: no ack within %0d cycles", name, WAIT_MAX);
      errors++;
    end

    op1_exp = source_value(src1, inst[19:15], inst, pc, ex_data, mem_data);
    op2_exp = source_value(src2, inst[24:20], inst, pc, ex_data, mem_data);
    sum     = op1_exp + {{(`ID_XLEN-12){inst[31]}}, inst[31:20]};
    redir_exp.en     = redir[0];
    redir_exp.target = redir[0] ? {sum[`ID_XLEN-1:1], 1'b0} : '0;

    check_class(name, id_pipe_pkg::inst_class_e'(cls), id_out.cls);
    check_op(name, id_pipe_pkg::id_op_e'(op), id_out.op);
    check_word(name, "rd_wen", rd_wen, id_out.rd_wen);
    check_word(name, "rd_addr", rd_addr, id_out.rd_addr);
    check_word(name, "op1", op1_exp, id_out.op1);
    check_word(name, "op2", op2_exp, id_out.op2);
    check_word(name, "mem_op", inst[14:12], id_out.mem_op);
    check_word(name, "mem_offset", mem_off, id_out.mem_offset);
    check_word(name, "pc", pc, id_out.pc);
    check_word(name, "inst", inst, id_out.inst);
    check_word(name, "rs1_addr", read_addr(src1, inst[19:15]), rs1_addr);
    check_word(name, "rs2_addr", read_addr(src2, inst[24:20]), rs2_addr);
    check_redirect(name, redir_exp, redirect);

    @(posedge clk);
    #2;
    req     = 1'b0;
    ex_fwd  = '0;
    mem_fwd = '0;
    wb      = '0;
    waited  = 0;
    while (ack !== 1'b0 && waited < WAIT_MAX) begin
      @(negedge clk);
      waited++;
    end
    if (ack !== 1'b0) begin
      $display("%s: ack did not fall after the request was dropped", name);
      errors++;
    end

    if (errors == 0) begin
      $display("test %s ok", name);
    end else begin
      $display("test %s: %0d mismatches", name, errors);
      n_fail++;
    end
  endtask

  initial begin
    wait (cases_loaded);
    #((n_cases + 4) * 20 * 2 * CLK_HALF);
    $display("watchdog: run did not finish within %0d cycles", (n_cases + 4) * 20);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    int    fd;
    int    code;
    string line;

    clk     = 1'b0;
    rst     = 1'b1;
    req     = 1'b0;
    fetch   = '0;
    ex_fwd  = '0;
    mem_fwd = '0;
    wb      = '0;
    n_tests = 0;
    n_fail  = 0;
    errors  = 0;
    void'($urandom(32'h6258));
    rf[0] = '0;
    for (int r = 1; r < 32; r++)
      rf[r] = {$urandom, $urandom};

    fd = $fopen("dv/id_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open dv/id_cases.txt");
      n_fail++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line.getc(0) != "#")
          lines.push_back(line);
      end
      $fclose(fd);
    end
    n_cases      = lines.size();
    cases_loaded = 1'b1;

    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;

    // state right after reset
    @(negedge clk);
    n_tests++;
    check_word("reset", "ack", '0, ack);
    check_word("reset", "redirect_en", '0, redirect.en);
    check_word("reset", "rd_wen", '0, id_out.rd_wen);
    check_op("reset", id_pipe_pkg::ILLEGAL, id_out.op);
    if (errors == 0) begin
      $display("test reset ok");
    end else begin
      $display("test reset: %0d mismatches", errors);
      n_fail++;
    end

    foreach (lines[i])
      run_case(lines[i]);

    $display("%0d tests, %0d failed, %0d assertion failures", n_tests, n_fail,
             UUT.u_chk.fail_count);
    if (n_fail == 0 && UUT.u_chk.fail_count == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/id_cases.txt ====
# name inst pc | ex: wen addr data is_load | mem: wen addr data | wb: wen addr
# expected: class op rd_wen rd_addr op1_src op2_src mem_offset redirect_en
add          002081b3 80000000 0 0 0 0 0 0 0 0 0 1 1 1 3 REG REG 000 0
sub          402081b3 80000004 0 0 0 0 0 0 0 0 0 1 2 1 3 REG REG 000 0
sra          4020d233 80000008 0 0 0 0 0 0 0 0 0 1 8 1 4 REG REG 000 0
addi_neg     ffd08293 8000000c 0 0 0 0 0 0 0 0 0 3 11 1 5 REG IMM 000 0
srai         4070d313 80000010 0 0 0 0 0 0 0 0 0 3 19 1 6 REG IMM 000 0
addw         002081bb 80000014 0 0 0 0 0 0 0 0 0 2 20 1 3 REG REG 000 0
subw         402081bb 80000018 0 0 0 0 0 0 0 0 0 2 21 1 3 REG REG 000 0
addiw        0100829b 8000001c 0 0 0 0 0 0 0 0 0 4 25 1 5 REG IMM 000 0
lui          800003b7 80000020 0 0 0 0 0 0 0 0 0 0 29 1 7 ZERO IMM 000 0
auipc        12345397 80001000 0 0 0 0 0 0 0 0 0 0 30 1 7 PC IMM 000 0
jal          008000ef 80001004 0 0 0 0 0 0 0 0 0 0 31 1 1 PC PC 000 0
beq          00208063 80001008 0 0 0 0 0 0 0 0 0 5 33 0 0 REG REG 000 0
bne          00209063 8000100c 0 0 0 0 0 0 0 0 0 5 34 0 0 REG REG 000 0
blt          0020c063 80001010 0 0 0 0 0 0 0 0 0 5 35 0 0 REG REG 000 0
bge          0020d063 80001014 0 0 0 0 0 0 0 0 0 5 36 0 0 REG REG 000 0
bltu         0020e063 80001018 0 0 0 0 0 0 0 0 0 5 37 0 0 REG REG 000 0
bgeu         0020f063 8000101c 0 0 0 0 0 0 0 0 0 5 38 0 0 REG REG 000 0
ld           ff80b283 80001020 0 0 0 0 0 0 0 0 0 6 0 1 5 REG ZERO ff8 0
sd           0020ba23 80001024 0 0 0 0 0 0 0 0 0 7 0 0 0 REG REG 014 0
sw_neg       fe20ae23 80001028 0 0 0 0 0 0 0 0 0 7 0 0 0 REG REG ffc 0
fwd_ex_mem   002081b3 8000102c 1 1 1234 0 1 1 5678 0 0 1 1 1 3 EX REG 000 0
fwd_mem      002081b3 80001030 0 0 0 0 1 1 5678 0 0 1 1 1 3 MEM REG 000 0
fwd_mem_rs2  002081b3 80001034 0 0 0 0 1 2 9abc 0 0 1 1 1 3 REG MEM 000 0
load_use     002081b3 80001038 1 2 dead 1 0 0 0 0 0 1 1 1 3 REG REG 000 0
jalr_nomatch 008100e7 8000103c 0 0 0 0 0 0 0 0 0 0 32 1 1 REG PC 000 0
jalr_ex      008100e7 80001040 1 2 1001 0 0 0 0 0 0 0 32 1 1 EX PC 000 1
jalr_mem     008100e7 80001044 0 0 0 0 1 2 3003 0 0 0 32 1 1 MEM PC 000 1
jalr_wb      008100e7 80001048 0 0 0 0 0 0 0 1 2 0 32 1 1 REG PC 000 1
addi_x0      00108013 8000104c 0 0 0 0 0 0 0 0 0 3 11 0 0 REG IMM 000 0
illegal      ffffffff 80001050 0 0 0 0 0 0 0 0 0 0 0 0 0 ZERO ZERO 000 0
mul          022081b3 80001054 0 0 0 0 0 0 0 0 0 0 0 0 0 ZERO ZERO 000 0

// ==== list.f ====
+incdir+common
common/rv_isa_pkg.sv
common/id_pipe_pkg.sv
decode/inst_decoder.sv
source/operand_bypass.sv
source/jalr_redirect.sv
source/id_handshake_reg.sv
source/id_stage_top.sv
dv/id_stage_chk.sv
dv/id_stage_tb.sv

// ==== Bender.yml ====
package:
  name: id_stage

export_include_dirs:
  - common

sources:
  - common/rv_isa_pkg.sv
  - common/id_pipe_pkg.sv
  - decode/inst_decoder.sv
  - source/operand_bypass.sv
  - source/jalr_redirect.sv
  - source/id_handshake_reg.sv
  - source/id_stage_top.sv
  - target: test
    files:
      - dv/id_stage_chk.sv
      - dv/id_stage_tb.sv
